/* hdl/rvPkg.sv */
/*
 * RV32I core package
 * Widths, opcode and funct encodings, ALU and forwarding enums, pipeline payloads
 */
package rvPkg;

    ////////////////////////////////////////
    // Widths
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      regAddr_t;

    localparam word_t resetPc = '0;                    // First fetch address

    ////////////////////////////////////////
    // Opcodes and function codes
    localparam logic [6:0] opCompute   = 7'b0110011;   // R-type ALU
    localparam logic [6:0] opImmediate = 7'b0010011;   // I-type ALU
    localparam logic [6:0] opLoad      = 7'b0000011;
    localparam logic [6:0] opStore     = 7'b0100011;
    localparam logic [6:0] opBranch    = 7'b1100011;
    localparam logic [6:0] opJump      = 7'b1101111;   // JAL only
    localparam logic [6:0] opLoadUpper = 7'b0110111;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

    localparam logic [6:0] f7Alt = 7'b0100000;         // Selects sub and sra

    ////////////////////////////////////////
    // ALU and forwarding selects
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluPassB
    } aluOp_t;

    typedef enum logic [1:0] {
        fwdReg, // Register file value
        fwdMem, // EX/MEM result
        fwdWb   // MEM/WB write data
    } fwdSel_t;

    ////////////////////////////////////////
    // Pipeline payloads
    typedef struct packed {
        word_t pc;
        word_t instr;
    } ifIdPayload_t;

    typedef struct packed {
        word_t    pc;
        word_t    rs1Val;
        word_t    rs2Val;
        word_t    imm;
        regAddr_t rs1;
        regAddr_t rs2;
        regAddr_t rd;
        aluOp_t   aluOp;
        logic     useImm;
        logic     isLoad;
        logic     isStore;
        logic     isBranch;
        logic     isJump;
        logic     regWrite;
        logic     branchOnNe;                           // Taken on not-equal
    } idExPayload_t;

    typedef struct packed {
        word_t    result;
        word_t    storeData;
        regAddr_t rd;
        logic     isLoad;
        logic     isStore;
        logic     regWrite;
    } exMemPayload_t;

    typedef struct packed {
        word_t    wrData;
        regAddr_t rd;
        logic     regWrite;
    } memWbPayload_t;

endpackage

/* hdl/stageReg.sv */
/*
 * Pipeline register with valid bit
 * Payload type set per instance, hold keeps contents, flush drops the entry
 */
`timescale 1ns/1ps

module stageReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arstN,
    input  logic     hold,
    input  logic     flush,
    input  logic     inValid,
    input  payload_t inData,
    output logic     outValid,
    output payload_t outData
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else if (flush) begin
            outValid <= 1'b0;                          // Flush beats hold
        end else if (!hold) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            outData <= inData;                         // Payload only, no reset
        end
    end

    validKnown: assert property (@(posedge clk) disable iff (!arstN) !$isunknown(outValid))
        else $error("Pipeline valid bit unknown");

endmodule

/* hdl/fetchStage.sv */
/*
 * Fetch stage program counter
 * Redirect load, hold, or sequential advance by one word
 */
`timescale 1ns/1ps

module fetchStage (
    input  logic         clk,
    input  logic         arstN,
    input  logic         hold,
    input  logic         redirect,
    input  rvPkg::word_t redirectPc,
    output rvPkg::word_t pc
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= rvPkg::resetPc;
        end else if (redirect) begin
            pc <= redirectPc;                          // Taken branch or JAL wins over stall
        end else if (!hold) begin
            pc <= pc + 32'd4;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("Fetch address not word aligned");

endmodule

/* hdl/decodeStage.sv */
/*
 * Instruction decode
 * Field split, immediate build, control flags and unsupported-opcode flag
 */
`timescale 1ns/1ps

module decodeStage (
    input  rvPkg::word_t    instr,
    input  logic            inValid,
    output rvPkg::regAddr_t rs1,
    output rvPkg::regAddr_t rs2,
    output rvPkg::regAddr_t rd,
    output rvPkg::word_t    imm,
    output rvPkg::aluOp_t   aluOp,
    output logic            useImm,
    output logic            usesRs2,
    output logic            isLoad,
    output logic            isStore,
    output logic            isBranch,
    output logic            isJump,
    output logic            regWrite,
    output logic            branchOnNe,
    output logic            unsupported
);

    logic [6:0]   opcode;
    logic [2:0]   f3;
    logic [6:0]   f7;
    rvPkg::word_t immI, immS, immB, immJ, immU;
    logic         rawWrite;
    logic         known;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign f7     = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign immU = {instr[31:12], 12'b0};

    always_comb begin
        aluOp      = rvPkg::aluAdd;                    // Address adder for loads and stores
        imm        = immI;
        useImm     = 1'b0;
        usesRs2    = 1'b0;
        isLoad     = 1'b0;
        isStore    = 1'b0;
        isBranch   = 1'b0;
        isJump     = 1'b0;
        rawWrite   = 1'b0;
        branchOnNe = (f3 == rvPkg::f3Bne);
        known      = 1'b1;
        case (opcode)
            rvPkg::opCompute, rvPkg::opImmediate: begin
                useImm   = (opcode == rvPkg::opImmediate);
                usesRs2  = !useImm;
                rawWrite = 1'b1;
                case (f3)
                    rvPkg::f3AddSub: aluOp = (!useImm && f7 == rvPkg::f7Alt) ? rvPkg::aluSub
                                                                             : rvPkg::aluAdd;
                    rvPkg::f3Sll:    aluOp = rvPkg::aluSll;
                    rvPkg::f3Slt:    aluOp = rvPkg::aluSlt;
                    rvPkg::f3Sltu:   aluOp = rvPkg::aluSltu;
                    rvPkg::f3Xor:    aluOp = rvPkg::aluXor;
                    rvPkg::f3SrlSra: aluOp = (f7 == rvPkg::f7Alt) ? rvPkg::aluSra  // srai too
                                                                  : rvPkg::aluSrl;
                    rvPkg::f3Or:     aluOp = rvPkg::aluOr;
                    default:         aluOp = rvPkg::aluAnd;
                endcase
            end
            rvPkg::opLoad: begin
                useImm   = 1'b1;
                isLoad   = 1'b1;
                rawWrite = 1'b1;
            end
            rvPkg::opStore: begin
                imm     = immS;
                useImm  = 1'b1;
                usesRs2 = 1'b1;                        // Store data
                isStore = 1'b1;
            end
            rvPkg::opBranch: begin
                imm      = immB;
                usesRs2  = 1'b1;
                isBranch = (f3 == rvPkg::f3Beq) || (f3 == rvPkg::f3Bne); // Others never taken
            end
            rvPkg::opJump: begin
                imm      = immJ;
                isJump   = 1'b1;
                rawWrite = 1'b1;                       // Link register
            end
            rvPkg::opLoadUpper: begin
                imm      = immU;
                aluOp    = rvPkg::aluPassB;
                useImm   = 1'b1;
                rawWrite = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    assign regWrite    = rawWrite && (rd != '0);       // x0 writes dropped here
    assign unsupported = inValid && !known;

endmodule

/* hdl/regFile.sv */
/*
 * Integer register file
 * Two read ports, one write port with write-through, x0 tied to zero
 */
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            arstN,
    input  rvPkg::regAddr_t rdAddrA,
    input  rvPkg::regAddr_t rdAddrB,
    output rvPkg::word_t    rdDataA,
    output rvPkg::word_t    rdDataB,
    input  logic            wrEn,
    input  rvPkg::regAddr_t wrAddr,
    input  rvPkg::word_t    wrData
);

    rvPkg::word_t regs [32];
    logic         wrLive;

    assign wrLive = wrEn && (wrAddr != '0);            // x0 never written

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write-back in the same cycle as decode reads the new value
    assign rdDataA = (wrLive && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrLive && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

    zeroReg: assert property (@(posedge clk) disable iff (!arstN)
        ((rdAddrA == '0) |-> (rdDataA == '0)) and ((rdAddrB == '0) |-> (rdDataB == '0)))
        else $error("x0 read returned nonzero");

endmodule

/* hdl/hazardUnit.sv */
/*
 * Hazard unit
 * Load-use stall and operand forwarding selects for execute
 */
`timescale 1ns/1ps

module hazardUnit (
    input  rvPkg::regAddr_t idRs1,
    input  rvPkg::regAddr_t idRs2,
    input  logic            idUsesRs2,
    input  rvPkg::regAddr_t exRs1,
    input  rvPkg::regAddr_t exRs2,
    input  rvPkg::regAddr_t exRd,
    input  logic            exValid,
    input  logic            exIsLoad,
    input  logic            exRegWrite,
    input  rvPkg::regAddr_t memRd,
    input  logic            memValid,
    input  logic            memRegWrite,
    input  rvPkg::regAddr_t wbRd,
    input  logic            wbRegWrite,
    output logic            stall,
    output rvPkg::fwdSel_t  fwdA,
    output rvPkg::fwdSel_t  fwdB
);

    logic memWrites;
    logic exLoadWrites;

    assign memWrites    = memValid && memRegWrite;     // rd nonzero when regWrite set
    assign exLoadWrites = exValid && exIsLoad && exRegWrite;

    // Load in execute feeding decode, data not ready before MEM/WB
    assign stall = exLoadWrites && ((exRd == idRs1) || (idUsesRs2 && exRd == idRs2));

    always_comb begin
        fwdA = rvPkg::fwdReg;
        fwdB = rvPkg::fwdReg;
        if (exValid) begin                             // Bubbles keep register values
            if (memWrites && memRd == exRs1) begin
                fwdA = rvPkg::fwdMem;                  // Younger producer first
            end else if (wbRegWrite && wbRd == exRs1) begin
                fwdA = rvPkg::fwdWb;
            end
            if (memWrites && memRd == exRs2) begin
                fwdB = rvPkg::fwdMem;
            end else if (wbRegWrite && wbRd == exRs2) begin
                fwdB = rvPkg::fwdWb;
            end
        end
    end

endmodule

/* hdl/executeUnit.sv */
/*
 * Execute stage datapath
 * Operand forwarding, ALU, BEQ/BNE compare, branch and JAL target and link
 */
`timescale 1ns/1ps

module executeUnit (
    input  rvPkg::word_t   pc,
    input  rvPkg::word_t   regA,
    input  rvPkg::word_t   regB,
    input  rvPkg::word_t   imm,
    input  rvPkg::aluOp_t  aluOp,
    input  logic           useImm,
    input  logic           isBranch,
    input  logic           isJump,
    input  logic           branchOnNe,
    input  logic           valid,
    input  rvPkg::fwdSel_t fwdA,
    input  rvPkg::fwdSel_t fwdB,
    input  rvPkg::word_t   memResult,
    input  rvPkg::word_t   wbResult,
    output rvPkg::word_t   result,
    output rvPkg::word_t   storeData,
    output rvPkg::word_t   redirectPc,
    output logic           redirect
);

    rvPkg::word_t srcA, srcB, aluB, aluOut;
    logic         taken;

    always_comb begin
        case (fwdA)
            rvPkg::fwdMem: srcA = memResult;
            rvPkg::fwdWb:  srcA = wbResult;
            default:       srcA = regA;
        endcase
        case (fwdB)
            rvPkg::fwdMem: srcB = memResult;
            rvPkg::fwdWb:  srcB = wbResult;
            default:       srcB = regB;
        endcase
    end

    assign aluB = useImm ? imm : srcB;

    always_comb begin
        case (aluOp)
            rvPkg::aluAdd:   aluOut = srcA + aluB;
            rvPkg::aluSub:   aluOut = srcA - aluB;
            rvPkg::aluSll:   aluOut = srcA << aluB[4:0];
            rvPkg::aluSlt:   aluOut = {31'b0, $signed(srcA) < $signed(aluB)};
            rvPkg::aluSltu:  aluOut = {31'b0, srcA < aluB};
            rvPkg::aluXor:   aluOut = srcA ^ aluB;
            rvPkg::aluSrl:   aluOut = srcA >> aluB[4:0];
            rvPkg::aluSra:   aluOut = $signed(srcA) >>> aluB[4:0];
            rvPkg::aluOr:    aluOut = srcA | aluB;
            rvPkg::aluAnd:   aluOut = srcA & aluB;
            rvPkg::aluPassB: aluOut = aluB;            // LUI
            default:         aluOut = '0;
        endcase
    end

    assign result    = isJump ? pc + 32'd4 : aluOut;   // JAL link address
    assign storeData = srcB;

    assign taken      = branchOnNe ? (srcA != srcB) : (srcA == srcB);
    assign redirect   = valid && (isJump || (isBranch && taken));
    assign redirectPc = pc + imm;

    always_comb begin
        if (redirect) begin
            targetAligned: assert final (redirectPc[1:0] == 2'b00)
                else $error("Branch or jump target not word aligned");
        end
    end

endmodule

/* hdl/rvCore.sv */
/*
 * Five-stage RV32I core top level
 * Pipeline registers, hazard wiring, memory stage select, halt latch
 */
`timescale 1ns/1ps

module rvCore (
    input  logic            clk,
    input  logic            arstN,
    output rvPkg::word_t    instrAddr,
    input  rvPkg::word_t    instrData,
    output rvPkg::word_t    dataAddr,
    output rvPkg::word_t    dataWrData,
    output logic            dataWrEn,
    input  rvPkg::word_t    dataRdData,
    output logic            wbValid,
    output rvPkg::regAddr_t wbRd,
    output rvPkg::word_t    wbData,
    output logic            halt
);

    rvPkg::word_t          pc, rdDataA, rdDataB, idImm, exResult, exStoreData, redirectPc;
    rvPkg::regAddr_t       idRs1, idRs2, idRd;
    rvPkg::aluOp_t         idAluOp;
    rvPkg::fwdSel_t        fwdA, fwdB;
    logic                  idUseImm, idUsesRs2, idIsLoad, idIsStore, idIsBranch, idIsJump;
    logic                  idRegWrite, idBranchOnNe, unsupported, stall, redirect;
    logic                  ifIdValid, idExValid, exMemValid, memWbValid;
    rvPkg::ifIdPayload_t   ifIdIn, ifId;
    rvPkg::idExPayload_t   idExIn, idEx;
    rvPkg::exMemPayload_t  exMemIn, exMem;
    rvPkg::memWbPayload_t  memWbIn, memWb;

    ////////////////////////////////////////
    // Fetch
    fetchStage uFetch (
        .clk(clk), .arstN(arstN), .hold(stall || halt),
        .redirect(redirect), .redirectPc(redirectPc), .pc(pc)
    );

    assign instrAddr = pc;
    assign ifIdIn    = '{pc: pc, instr: instrData};

    stageReg #(.payload_t(rvPkg::ifIdPayload_t)) uIfId (
        .clk(clk), .arstN(arstN), .hold(stall), .flush(redirect),
        .inValid(!halt), .inData(ifIdIn), .outValid(ifIdValid), .outData(ifId)
    );

    ////////////////////////////////////////
    // Decode
    decodeStage uDecode (
        .instr(ifId.instr), .inValid(ifIdValid), .rs1(idRs1), .rs2(idRs2), .rd(idRd),
        .imm(idImm), .aluOp(idAluOp), .useImm(idUseImm), .usesRs2(idUsesRs2),
        .isLoad(idIsLoad), .isStore(idIsStore), .isBranch(idIsBranch), .isJump(idIsJump),
        .regWrite(idRegWrite), .branchOnNe(idBranchOnNe), .unsupported(unsupported)
    );

    regFile uRegs (
        .clk(clk), .arstN(arstN), .rdAddrA(idRs1), .rdAddrB(idRs2),
        .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(wbValid), .wrAddr(memWb.rd), .wrData(memWb.wrData)
    );

    hazardUnit uHazard (
        .idRs1(idRs1), .idRs2(idRs2), .idUsesRs2(idUsesRs2),
        .exRs1(idEx.rs1), .exRs2(idEx.rs2), .exRd(idEx.rd), .exValid(idExValid),
        .exIsLoad(idEx.isLoad), .exRegWrite(idEx.regWrite),
        .memRd(exMem.rd), .memValid(exMemValid), .memRegWrite(exMem.regWrite),
        .wbRd(memWb.rd), .wbRegWrite(wbValid), .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
    );

    // Sticky halt, a wrong-path word squashed by redirect does not count
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            halt <= 1'b0;
        end else if (unsupported && !redirect) begin
            halt <= 1'b1;
        end
    end

    assign idExIn = '{pc: ifId.pc, rs1Val: rdDataA, rs2Val: rdDataB, imm: idImm,
                      rs1: idRs1, rs2: idRs2, rd: idRd, aluOp: idAluOp, useImm: idUseImm,
                      isLoad: idIsLoad, isStore: idIsStore, isBranch: idIsBranch,
                      isJump: idIsJump, regWrite: idRegWrite, branchOnNe: idBranchOnNe};

    // Stall inserts a bubble, halting word and younger never enter execute
    stageReg #(.payload_t(rvPkg::idExPayload_t)) uIdEx (
        .clk(clk), .arstN(arstN), .hold(1'b0), .flush(redirect || stall),
        .inValid(ifIdValid && !unsupported && !halt), .inData(idExIn),
        .outValid(idExValid), .outData(idEx)
    );

    ////////////////////////////////////////
    // Execute
    executeUnit uExecute (
        .pc(idEx.pc), .regA(idEx.rs1Val), .regB(idEx.rs2Val), .imm(idEx.imm),
        .aluOp(idEx.aluOp), .useImm(idEx.useImm), .isBranch(idEx.isBranch),
        .isJump(idEx.isJump), .branchOnNe(idEx.branchOnNe), .valid(idExValid),
        .fwdA(fwdA), .fwdB(fwdB), .memResult(exMem.result), .wbResult(memWb.wrData),
        .result(exResult), .storeData(exStoreData), .redirectPc(redirectPc),
        .redirect(redirect)
    );

    assign exMemIn = '{result: exResult, storeData: exStoreData, rd: idEx.rd,
                       isLoad: idEx.isLoad, isStore: idEx.isStore, regWrite: idEx.regWrite};

    stageReg #(.payload_t(rvPkg::exMemPayload_t)) uExMem (
        .clk(clk), .arstN(arstN), .hold(1'b0), .flush(1'b0),
        .inValid(idExValid), .inData(exMemIn), .outValid(exMemValid), .outData(exMem)
    );

    ////////////////////////////////////////
    // Memory and write-back
    assign dataAddr   = exMem.result;
    assign dataWrData = exMem.storeData;
    assign dataWrEn   = exMemValid && exMem.isStore;   // Single pulse per store
    assign memWbIn    = '{wrData: exMem.isLoad ? dataRdData : exMem.result,
                          rd: exMem.rd, regWrite: exMem.regWrite};

    stageReg #(.payload_t(rvPkg::memWbPayload_t)) uMemWb (
        .clk(clk), .arstN(arstN), .hold(1'b0), .flush(1'b0),
        .inValid(exMemValid), .inData(memWbIn), .outValid(memWbValid), .outData(memWb)
    );

    assign wbValid = memWbValid && memWb.regWrite;
    assign wbRd    = memWb.rd;
    assign wbData  = memWb.wrData;

    // Load data is never forwarded from EX/MEM, the stall must cover it
    noLoadFwd: assert property (@(posedge clk) disable iff (!arstN)
        (exMemValid && exMem.isLoad) |-> (fwdA != rvPkg::fwdMem && fwdB != rvPkg::fwdMem))
        else $error("Forwarding from a load still in memory stage");

endmodule

/* include/testProgram.svh */
/*
 * Test program for the RV32I core
 * Instruction words, expected write-backs {rd, data} and stores {addr, data}
 */
`ifndef TEST_PROGRAM_SVH
`define TEST_PROGRAM_SVH

localparam int progLen = 26;

localparam logic [31:0] progWords [progLen] = '{
    32'h00500093, // 00 addi x1, x0, 5
    32'hFFD00113, // 04 addi x2, x0, -3
    32'h002081B3, // 08 add  x3, x1, x2
    32'h40208233, // 0c sub  x4, x1, x2
    32'h001122B3, // 10 slt  x5, x2, x1
    32'h00113333, // 14 sltu x6, x2, x1
    32'h0041C3B3, // 18 xor  x7, x3, x4
    32'h00309433, // 1c sll  x8, x1, x3
    32'h403154B3, // 20 sra  x9, x2, x3
    32'h01C15513, // 24 srli x10, x2, 28
    32'h123455B7, // 28 lui  x11, 0x12345
    32'h6785E613, // 2c ori  x12, x11, 0x678
    32'h00C02823, // 30 sw   x12, 16(x0)
    32'h01002683, // 34 lw   x13, 16(x0)
    32'h0046F733, // 38 and  x14, x13, x4
    32'h00470663, // 3c beq  x14, x4, +12
    32'h00100793, // 40 addi x15, x0, 1
    32'h00002A23, // 44 sw   x0, 20(x0)
    32'h00109463, // 48 bne  x1, x1, +8
    32'h00C0086F, // 4c jal  x16, +12
    32'h00200893, // 50 addi x17, x0, 2
    32'h00300913, // 54 addi x18, x0, 3
    32'h01002A23, // 58 sw   x16, 20(x0)
    32'h001869B3, // 5c or   x19, x16, x1
    32'hFFFFFFFF, // 60 Unsupported opcode
    32'h00700A13  // 64 addi x20, x0, 7
};

localparam int expWbLen = 16;

localparam logic [36:0] expWb [expWbLen] = '{
    {5'd1,  32'h00000005}, {5'd2,  32'hFFFFFFFD},
    {5'd3,  32'h00000002}, {5'd4,  32'h00000008},
    {5'd5,  32'h00000001}, {5'd6,  32'h00000000},
    {5'd7,  32'h0000000A}, {5'd8,  32'h00000014},
    {5'd9,  32'hFFFFFFFF}, {5'd10, 32'h0000000F},
    {5'd11, 32'h12345000}, {5'd12, 32'h12345678},
    {5'd13, 32'h12345678}, {5'd14, 32'h00000008},
    {5'd16, 32'h00000050}, {5'd19, 32'h00000055}
};

localparam int expStLen = 2;

localparam logic [63:0] expSt [expStLen] = '{
    {32'h00000010, 32'h12345678},
    {32'h00000014, 32'h00000050}
};

`endif

/* verif/coreTb.sv */
/*
 * Testbench for the RV32I core
 * Memory models run the test program, write-backs and stores checked in order
 */
`timescale 1ns/1ps

module coreTb;

    logic            clk;
    logic            arstN;
    rvPkg::word_t    instrAddr, instrData;
    rvPkg::word_t    dataAddr, dataWrData, dataRdData;
    logic            dataWrEn;
    logic            wbValid;
    rvPkg::regAddr_t wbRd;
    rvPkg::word_t    wbData;
    logic            halt;

    `include "testProgram.svh"

    localparam int cycleLimit = 20 * progLen;          // Far above the pipelined run time

    rvPkg::word_t dmem [64];
    int           wbIdx;
    int           stIdx;
    int           wbErrors;
    int           stErrors;
    int           otherErrors;
    int           cycles;
    logic         timedOut;

    ////////////////////////////////////////
    // Clock and DUT
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                         // 10 ns period
    end

    rvCore dut (
        .clk(clk), .arstN(arstN),
        .instrAddr(instrAddr), .instrData(instrData),
        .dataAddr(dataAddr), .dataWrData(dataWrData), .dataWrEn(dataWrEn),
        .dataRdData(dataRdData),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData), .halt(halt)
    );

    ////////////////////////////////////////
    // Memory models
    // Past the program end the fetch sees a nop
    assign instrData = (instrAddr[31:2] < progLen) ? progWords[instrAddr[31:2]] : 32'h00000013;
    assign dataRdData = dmem[dataAddr[7:2]];           // Combinational read

    initial begin
        void'($urandom(32'h18a9));                     // One seed for the run
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $urandom;                        // Loads only hit stored words
        end
    end

    always @(posedge clk) begin
        if (dataWrEn) begin
            dmem[dataAddr[7:2]] <= dataWrData;
        end
    end

    ////////////////////////////////////////
    // In-order checks
    always @(posedge clk) begin
        if (arstN && wbValid) begin
            wbInRange: assert (wbIdx < expWbLen)
                else begin
                    wbErrors++;
                    $display("Fail at %t: extra write-back x%0d = %h", $time, wbRd, wbData);
                end
            if (wbIdx < expWbLen) begin
                wbMatch: assert ({wbRd, wbData} == expWb[wbIdx])
                    else begin
                        wbErrors++;
                        $display("Fail at %t: write-back %0d is x%0d = %h, expected x%0d = %h",
                                 $time, wbIdx, wbRd, wbData,
                                 expWb[wbIdx][36:32], expWb[wbIdx][31:0]);
                    end
            end
            wbIdx++;
        end
    end

    always @(posedge clk) begin
        if (arstN && dataWrEn) begin
            stInRange: assert (stIdx < expStLen)
                else begin
                    stErrors++;
                    $display("Fail at %t: extra store %h to %h", $time, dataWrData, dataAddr);
                end
            if (stIdx < expStLen) begin
                stMatch: assert ({dataAddr, dataWrData} == expSt[stIdx])
                    else begin
                        stErrors++;
                        $display("Fail at %t: store %0d is %h at %h, expected %h at %h",
                                 $time, stIdx, dataWrData, dataAddr,
                                 expSt[stIdx][31:0], expSt[stIdx][63:32]);
                    end
            end
            stIdx++;
        end
    end

    haltSticky: assert property (@(posedge clk) disable iff (!arstN) halt |=> halt)
        else begin
            otherErrors++;
            $display("Fail at %t: halt dropped before reset", $time);
        end

    // Only the two older instructions past decode drain after halt
    quietAfterHalt: assert property (@(posedge clk) disable iff (!arstN)
        $past(halt, 2) |-> (!wbValid && !dataWrEn))
        else begin
            otherErrors++;
            $display("Fail at %t: retirement after halt drained", $time);
        end

    ////////////////////////////////////////
    // Reset, run and report
    initial begin
        $timeformat(-9, 0, " ns", 0);
        arstN       = 1'b0;
        wbIdx       = 0;
        stIdx       = 0;
        wbErrors    = 0;
        stErrors    = 0;
        otherErrors = 0;
        cycles      = 0;
        timedOut    = 1'b0;
        repeat (16) @(posedge clk);
        resetIdle: assert (!wbValid && !dataWrEn && !halt && instrAddr == rvPkg::resetPc)
            else begin
                otherErrors++;
                $display("Fail at %t: outputs not idle during reset", $time);
            end
        arstN <= 1'b1;
        while (!halt && cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (!halt) begin
            timedOut = 1'b1;
            $display("Halt never came within %0d cycles", cycleLimit);
        end else begin
            repeat (4) @(posedge clk);                 // Drain and watch for stray pulses
            allRetired: assert (wbIdx == expWbLen && stIdx == expStLen)
                else begin
                    otherErrors++;
                    $display("Fail at %t: saw %0d of %0d write-backs and %0d of %0d stores",
                             $time, wbIdx, expWbLen, stIdx, expStLen);
                end
        end
        $display("Errors: write-back %0d, store %0d, other %0d, timeout %0d",
                 wbErrors, stErrors, otherErrors, timedOut);
        if (wbErrors == 0 && stErrors == 0 && otherErrors == 0 && !timedOut) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
hdl/rvPkg.sv
hdl/stageReg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/executeUnit.sv
hdl/rvCore.sv
verif/coreTb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - hdl/rvPkg.sv
  - hdl/stageReg.sv
  - hdl/fetchStage.sv
  - hdl/decodeStage.sv
  - hdl/regFile.sv
  - hdl/hazardUnit.sv
  - hdl/executeUnit.sv
  - hdl/rvCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/coreTb.sv
